/* rtl/mcalu_defs.svh */
// Width and iteration-count macros for the multi-cycle integer execution unit
`ifndef MCALU_DEFS_SVH
`define MCALU_DEFS_SVH

// Operand and result width
`define XLEN 32

// Reorder-buffer tag width
`define ROBID_W 7

// Physical destination register width
`define RD_W 6

// Operation word width
`define OP_W 5

// Radix-4 Booth accumulate cycles, two multiplier bits each
`define MUL_STEPS 16

// Restoring divide cycles, one quotient bit each
`define DIV_STEPS 32

`endif

/* rtl/mcalu_op_pkg.sv */
// Operation word layouts, their packed union and the named operation codes
`include "mcalu_defs.svh"

package mcalu_op_pkg;

  // Base and priority operations
  typedef struct packed {
    logic       ext;
    logic       alt;
    logic [2:0] func;
  } mcalu_simple_op_t;

  // Multiply and divide
  typedef struct packed {
    logic [1:0] cls;
    logic       div;
    logic       hi;
    logic       sel;
  } mcalu_mc_op_t;

  typedef union packed {
    mcalu_simple_op_t simple;
    mcalu_mc_op_t     mc;
  } mcalu_op_u;

  // Class field value of every multi-cycle operation
  localparam logic [1:0] MC_CLASS = 2'b11;

  localparam logic [`OP_W-1:0] OP_ADD    = 5'b00000;
  localparam logic [`OP_W-1:0] OP_SUB    = 5'b01000;
  localparam logic [`OP_W-1:0] OP_SLL    = 5'b00001;
  localparam logic [`OP_W-1:0] OP_SLT    = 5'b00010;
  localparam logic [`OP_W-1:0] OP_SLTU   = 5'b00011;
  localparam logic [`OP_W-1:0] OP_XOR    = 5'b00100;
  localparam logic [`OP_W-1:0] OP_SEQ    = 5'b01100;
  localparam logic [`OP_W-1:0] OP_SRL    = 5'b00101;
  localparam logic [`OP_W-1:0] OP_SRA    = 5'b01101;
  localparam logic [`OP_W-1:0] OP_OR     = 5'b00110;
  localparam logic [`OP_W-1:0] OP_AND    = 5'b00111;
  localparam logic [`OP_W-1:0] OP_PFIND  = 5'b10000;
  localparam logic [`OP_W-1:0] OP_PCLR   = 5'b10001;
  localparam logic [`OP_W-1:0] OP_MUL    = 5'b11000;
  localparam logic [`OP_W-1:0] OP_MULH   = 5'b11001;
  localparam logic [`OP_W-1:0] OP_MULHSU = 5'b11010;
  localparam logic [`OP_W-1:0] OP_MULHU  = 5'b11011;
  localparam logic [`OP_W-1:0] OP_DIV    = 5'b11100;
  localparam logic [`OP_W-1:0] OP_DIVU   = 5'b11101;
  localparam logic [`OP_W-1:0] OP_REM    = 5'b11110;
  localparam logic [`OP_W-1:0] OP_REMU   = 5'b11111;

endpackage

/* rtl/mcalu_fu_pkg.sv */
// Functional-unit selection type and the operation-to-unit mapping
package mcalu_fu_pkg;

  import mcalu_op_pkg::*;

  typedef enum logic [1:0] {
    FU_SIMPLE = 2'd0,
    FU_MUL    = 2'd1,
    FU_DIV    = 2'd2
  } fu_sel_e;

  // Multi-cycle class splits on the divide flag
  function automatic fu_sel_e op_fu(input mcalu_op_u op);
    fu_sel_e fu;
    if (op.mc.cls != MC_CLASS) begin
      fu = FU_SIMPLE;
    end else if (op.mc.div) begin
      fu = FU_DIV;
    end else begin
      fu = FU_MUL;
    end
    return fu;
  endfunction

endpackage

/* rtl/simple_alu.sv */
// Combinational base ALU with priority find and priority clear
`timescale 1ns/1ps
`include "mcalu_defs.svh"

module simple_alu
  import mcalu_op_pkg::*;
(
  input  mcalu_op_u          op,
  input  logic [`XLEN-1:0]   op1,
  input  logic [`XLEN-1:0]   op2,
  output logic [`XLEN-1:0]   result
);

  localparam int IDX_W = $clog2(`XLEN);

  logic [IDX_W-1:0]  shamt;
  logic [`XLEN-1:0]  sra;
  logic              slt;
  logic              sltu;
  logic              seq;

  // Priority candidates: set in op1, clear in op2
  logic [`XLEN-1:0]  cand;
  logic [`XLEN-1:0]  low;
  logic              none;
  logic [IDX_W-1:0]  idx;

  assign shamt = op2[IDX_W-1:0];

  // Kept apart so the arithmetic shift stays signed
  assign sra  = $signed(op1) >>> shamt;
  assign slt  = $signed(op1) < $signed(op2);
  assign sltu = op1 < op2;
  assign seq  = op1 == op2;

  assign cand = op1 & ~op2;
  // Isolate lowest set bit
  assign low  = cand & (~cand + 1'b1);
  assign none = ~|cand;

  // Scan from the top so the lowest bit wins
  always_comb begin
    idx = '0;
    for (int i = `XLEN - 1; i >= 0; i--) begin
      if (cand[i]) begin
        idx = IDX_W'(i);
      end
    end
  end

  always_comb begin
    result = '0;
    if (!op.simple.ext) begin
      case (op.simple.func)
        3'b000: result = op.simple.alt ? op1 - op2 : op1 + op2;
        3'b001: result = op1 << shamt;
        3'b010: result = {{(`XLEN-1){1'b0}}, slt};
        3'b011: result = {{(`XLEN-1){1'b0}}, sltu};
        3'b100: result = op.simple.alt ? {{(`XLEN-1){1'b0}}, seq} : op1 ^ op2;
        3'b101: result = op.simple.alt ? sra : op1 >> shamt;
        3'b110: result = op1 | op2;
        default: result = op1 & op2;
      endcase
    end else begin
      case (op.simple.func)
        // Top bit flags an empty candidate set
        3'b000: result = {none, {(`XLEN-1-IDX_W){1'b0}}, idx};
        3'b001: result = op1 & ~low;
        default: result = '0;
      endcase
    end
  end

endmodule

/* rtl/booth_mul.sv */
// Iterative radix-4 Booth multiplier for MUL, MULH, MULHSU and MULHU
`timescale 1ns/1ps
`include "mcalu_defs.svh"

module booth_mul
  import mcalu_op_pkg::*;
(
  input  logic               clk,
  input  logic               arst_n,
  input  logic               flush,
  input  logic               start,
  input  mcalu_op_u          op,
  input  logic [`XLEN-1:0]   op1,
  input  logic [`XLEN-1:0]   op2,
  output logic               done,
  output logic [`XLEN-1:0]   product_sel
);

  localparam logic [1:0] S_IDLE  = 2'd0;
  localparam logic [1:0] S_ACC   = 2'd1;
  localparam logic [1:0] S_FINAL = 2'd2;

  // Two guard bits above the 64-bit product
  localparam int ACC_W = 2 * `XLEN + 2;
  localparam int PP_W  = `XLEN + 2;
  localparam int CNT_W = $clog2(`MUL_STEPS);

  logic [1:0]        state;
  logic [CNT_W-1:0]  cnt;
  logic [ACC_W-1:0]  acc;
  logic              x0;
  logic              inv;

  logic              load;
  logic              x2;
  logic              x1;
  logic              single;
  logic              dbl;
  logic              neg;
  logic              se_bit;
  logic              op2_unsigned;
  logic [PP_W-1:0]   pp;
  logic [PP_W-1:0]   pp_last;
  logic [ACC_W-1:0]  acc_shr;
  logic [ACC_W-1:0]  acc_step;
  logic [ACC_W-1:0]  acc_last;

  assign load = start && (state != S_ACC);

  // Booth recode of two multiplier bits plus the carried bit
  assign {x2, x1} = acc[1:0];
  assign single   = x1 ^ x0;
  assign dbl      = (~x2 & x1 & x0) | (x2 & ~x1 & ~x0);
  assign neg      = x2;

  // op1 signed for MULH and MULHSU, op2 signed only for MULH
  assign se_bit       = op1[`XLEN-1] & (op.mc.hi ^ op.mc.sel);
  assign op2_unsigned = ~(~op.mc.hi & op.mc.sel);

  // Negation by inversion, the +1 follows one step later through inv
  always_comb begin
    if (single) begin
      pp = {PP_W{neg}} ^ {se_bit, se_bit, op1};
    end else if (dbl) begin
      pp = {PP_W{neg}} ^ {se_bit, op1, 1'b0};
    end else begin
      pp = {PP_W{neg}};
    end
  end

  // Unsigned multiplier needs one more positive digit from its top bit
  assign pp_last = (x0 && op2_unsigned) ? {se_bit, se_bit, op1} : '0;

  assign acc_shr  = $signed(acc) >>> 2;
  assign acc_step = acc_shr + {pp, 1'b0, inv, {(`XLEN-2){1'b0}}};
  assign acc_last = acc_shr + {pp_last, 1'b0, inv, {(`XLEN-2){1'b0}}};

  assign done        = state == S_FINAL;
  assign product_sel = (op.mc.hi | op.mc.sel) ? acc_last[2*`XLEN-1:`XLEN]
                                              : acc_last[`XLEN-1:0];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state <= S_IDLE;
      cnt   <= '0;
    end else if (flush) begin
      state <= S_IDLE;
    end else if (load) begin
      state <= S_ACC;
      cnt   <= CNT_W'(`MUL_STEPS - 1);
    end else if (state == S_ACC) begin
      if (cnt == '0) begin
        state <= S_FINAL;
      end else begin
        cnt <= cnt - 1'b1;
      end
    end
  end

  // Multiplier sits in the low half and shifts out two bits per step
  always_ff @(posedge clk) begin
    if (load) begin
      acc <= {{(`XLEN+2){1'b0}}, op2};
      x0  <= 1'b0;
      inv <= 1'b0;
    end else if (state == S_ACC) begin
      acc <= acc_step;
      x0  <= acc[1];
      inv <= neg;
    end
  end

  // Product only appears after a full setup and accumulate sequence
  assert property (@(posedge clk) disable iff (!arst_n)
    $rose(done) |-> $past(start, `MUL_STEPS + 1));

endmodule

/* rtl/restoring_div.sv */
// Iterative restoring divider for DIV, DIVU, REM and REMU with sign fixup
`timescale 1ns/1ps
`include "mcalu_defs.svh"

module restoring_div
  import mcalu_op_pkg::*;
(
  input  logic               clk,
  input  logic               arst_n,
  input  logic               flush,
  input  logic               start,
  input  mcalu_op_u          op,
  input  logic [`XLEN-1:0]   op1,
  input  logic [`XLEN-1:0]   op2,
  output logic               done,
  output logic [`XLEN-1:0]   quotient_sel
);

  localparam logic [1:0] S_IDLE  = 2'd0;
  localparam logic [1:0] S_STEP  = 2'd1;
  localparam logic [1:0] S_FINAL = 2'd2;

  localparam int CNT_W = $clog2(`DIV_STEPS);

  logic [1:0]          state;
  logic [CNT_W-1:0]    cnt;
  // Partial remainder above, dividend turning into quotient below
  logic [2*`XLEN-1:0]  acc;
  logic [`XLEN+1:0]    ndsor;
  logic                dvd_sgn;
  logic                quo_neg;

  logic                load;
  logic                dvd_neg_in;
  logic                dsor_neg_in;
  logic [`XLEN-1:0]    abs_op1;
  logic [`XLEN-1:0]    abs_op2;
  logic [`XLEN:0]      rem_sh;
  logic [`XLEN+1:0]    trial;
  logic                qbit;
  logic [`XLEN-1:0]    rem_nx;
  logic [`XLEN-1:0]    quo_fix;
  logic [`XLEN-1:0]    rem_fix;

  assign load = start && (state != S_STEP);

  // sel marks the unsigned forms
  assign dvd_neg_in  = op1[`XLEN-1] & ~op.mc.sel;
  assign dsor_neg_in = op2[`XLEN-1] & ~op.mc.sel;
  assign abs_op1     = dvd_neg_in ? -op1 : op1;
  assign abs_op2     = dsor_neg_in ? -op2 : op2;

  // Trial subtract by adding the stored negated divisor
  assign rem_sh = {acc[2*`XLEN-1:`XLEN], acc[`XLEN-1]};
  assign trial  = {1'b0, rem_sh} + ndsor;
  assign qbit   = ~trial[`XLEN+1];
  assign rem_nx = qbit ? trial[`XLEN-1:0] : rem_sh[`XLEN-1:0];

  assign quo_fix = quo_neg ? -acc[`XLEN-1:0] : acc[`XLEN-1:0];
  assign rem_fix = dvd_sgn ? -acc[2*`XLEN-1:`XLEN] : acc[2*`XLEN-1:`XLEN];

  assign done         = state == S_FINAL;
  assign quotient_sel = op.mc.hi ? rem_fix : quo_fix;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state <= S_IDLE;
      cnt   <= '0;
    end else if (flush) begin
      state <= S_IDLE;
    end else if (load) begin
      state <= S_STEP;
      cnt   <= CNT_W'(`DIV_STEPS - 1);
    end else if (state == S_STEP) begin
      if (cnt == '0) begin
        state <= S_FINAL;
      end else begin
        cnt <= cnt - 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      acc     <= {{`XLEN{1'b0}}, abs_op1};
      ndsor   <= -{2'b00, abs_op2};
      dvd_sgn <= dvd_neg_in;
      // Divide by zero keeps the all-ones quotient
      quo_neg <= (dvd_neg_in ^ dsor_neg_in) & (|op2);
    end else if (state == S_STEP) begin
      acc <= {rem_nx, acc[`XLEN-2:0], qbit};
    end
  end

  // Counter moves only on a load or inside the restoring loop
  assert property (@(posedge clk) disable iff (!arst_n)
    (state != S_STEP && !start) |=> $stable(cnt));

endmodule

/* rtl/mcalu.sv */
// Execution unit top: issue latch, stall, unit dispatch, result select and flush
`timescale 1ns/1ps
`include "mcalu_defs.svh"

module mcalu
  import mcalu_op_pkg::*, mcalu_fu_pkg::*;
(
  input  logic                 clk,
  input  logic                 arst_n,
  // Issue side
  input  logic                 issue,
  input  mcalu_op_u            op,
  input  logic [`ROBID_W-1:0]  robid,
  input  logic [`RD_W-1:0]     rd,
  input  logic [`XLEN-1:0]     op1,
  input  logic [`XLEN-1:0]     op2,
  output logic                 stall,
  // Writeback side
  output logic                 wb_valid,
  output logic [`ROBID_W-1:0]  wb_robid,
  output logic [`RD_W-1:0]     wb_rd,
  output logic [`XLEN-1:0]     wb_result,
  input  logic                 wb_stall,
  // Reorder buffer
  input  logic                 flush
);

  // Held operation
  logic                 valid;
  fu_sel_e              fu_q;
  logic                 start_q;
  mcalu_op_u            op_q;
  logic [`ROBID_W-1:0]  robid_q;
  logic [`RD_W-1:0]     rd_q;
  logic [`XLEN-1:0]     op1_q;
  logic [`XLEN-1:0]     op2_q;

  logic                 accept;
  logic                 unit_done;
  logic [`XLEN-1:0]     simple_result;
  logic                 mul_done;
  logic [`XLEN-1:0]     mul_result;
  logic                 div_done;
  logic [`XLEN-1:0]     div_result;

  assign accept = issue & ~stall;

  // Flush wins over an issue on the same edge
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      valid   <= 1'b0;
      fu_q    <= FU_SIMPLE;
      start_q <= 1'b0;
    end else if (flush) begin
      valid   <= 1'b0;
      start_q <= 1'b0;
    end else begin
      start_q <= accept && (op_fu(op) != FU_SIMPLE);
      if (!stall) begin
        valid <= issue;
      end
      if (accept) begin
        fu_q <= op_fu(op);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      op_q    <= op;
      robid_q <= robid;
      rd_q    <= rd;
      op1_q   <= op1;
      op2_q   <= op2;
    end
  end

  simple_alu u_simple (
    .op     (op_q),
    .op1    (op1_q),
    .op2    (op2_q),
    .result (simple_result)
  );

  booth_mul u_mul (
    .clk         (clk),
    .arst_n      (arst_n),
    .flush       (flush),
    .start       (start_q && fu_q == FU_MUL),
    .op          (op_q),
    .op1         (op1_q),
    .op2         (op2_q),
    .done        (mul_done),
    .product_sel (mul_result)
  );

  restoring_div u_div (
    .clk          (clk),
    .arst_n       (arst_n),
    .flush        (flush),
    .start        (start_q && fu_q == FU_DIV),
    .op           (op_q),
    .op1          (op1_q),
    .op2          (op2_q),
    .done         (div_done),
    .quotient_sel (div_result)
  );

  // A unit still shows the previous result while its start is pending
  always_comb begin
    case (fu_q)
      FU_MUL: begin
        unit_done = mul_done & ~start_q;
        wb_result = mul_result;
      end
      FU_DIV: begin
        unit_done = div_done & ~start_q;
        wb_result = div_result;
      end
      default: begin
        unit_done = 1'b1;
        wb_result = simple_result;
      end
    endcase
  end

  assign stall    = valid & (~unit_done | wb_stall);
  assign wb_valid = valid & unit_done;
  assign wb_robid = robid_q;
  assign wb_rd    = rd_q;

  // A stalled operation stays held until it is taken
  assert property (@(posedge clk) disable iff (!arst_n)
    stall && !flush |=> valid);

  assert property (@(posedge clk) disable iff (!arst_n)
    flush |=> !wb_valid);

endmodule

/* dv/mcalu_model.svh */
// Reference results for every operation, expected latency and the Galois LFSR
`ifndef MCALU_MODEL_SVH
`define MCALU_MODEL_SVH

// Galois LFSR for x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_step(input logic [31:0] s);
  return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
endfunction

// One LFSR step per bit taken
function automatic logic [31:0] draw(inout logic [31:0] st, input int n);
  logic [31:0] v;
  v = '0;
  for (int i = 0; i < n; i++) begin
    st = lfsr_step(st);
    v = {v[30:0], st[0]};
  end
  return v;
endfunction

function automatic logic [31:0] corner(input int i);
  case (i)
    0: return 32'h0000_0000;
    1: return 32'h0000_0001;
    2: return 32'hffff_ffff;
    default: return 32'h8000_0000;
  endcase
endfunction

// Lowest bit set in a and clear in b
function automatic logic [31:0] ref_prio(input logic [31:0] a, b, input logic clear);
  logic [31:0] r;
  logic found;
  r = clear ? a : 32'h8000_0000;
  found = 1'b0;
  for (int i = 0; i < 32; i++) begin
    if (!found && a[i] && !b[i]) begin
      found = 1'b1;
      r = clear ? (a & ~(32'h1 << i)) : 32'(i);
    end
  end
  return r;
endfunction

function automatic logic [31:0] ref_simple(input logic [4:0] code, input logic [31:0] a, b);
  case (code)
    OP_ADD:   return a + b;
    OP_SUB:   return a - b;
    OP_SLL:   return a << b[4:0];
    OP_SLT:   return {31'b0, $signed(a) < $signed(b)};
    OP_SLTU:  return {31'b0, a < b};
    OP_XOR:   return a ^ b;
    OP_SEQ:   return {31'b0, a == b};
    OP_SRL:   return a >> b[4:0];
    OP_SRA:   return $signed(a) >>> b[4:0];
    OP_OR:    return a | b;
    OP_AND:   return a & b;
    OP_PFIND: return ref_prio(a, b, 1'b0);
    OP_PCLR:  return ref_prio(a, b, 1'b1);
    default:  return '0;
  endcase
endfunction

// Full 64-bit product of the extended operands
function automatic logic [31:0] ref_mul(input logic [4:0] code, input logic [31:0] a, b);
  logic [63:0] sa;
  logic [63:0] sb;
  logic [63:0] ub;
  logic [63:0] p;
  sa = {{32{a[31]}}, a};
  sb = {{32{b[31]}}, b};
  ub = {32'b0, b};
  case (code)
    OP_MULHSU: p = sa * ub;
    OP_MULHU:  p = {32'b0, a} * ub;
    default:   p = sa * sb;
  endcase
  return (code == OP_MUL) ? p[31:0] : p[63:32];
endfunction

// Divide by zero gives all ones or the dividend, overflow gives the dividend or zero
function automatic logic [31:0] ref_div(input logic [4:0] code, input logic [31:0] a, b);
  logic               ovf;
  logic signed [31:0] sq;
  logic signed [31:0] sr;
  ovf = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
  sq  = '0;
  sr  = '0;
  // Signed quotient and remainder, truncated toward zero
  if (b != 0 && !ovf) begin
    sq = $signed(a) / $signed(b);
    sr = $signed(a) % $signed(b);
  end
  case (code)
    OP_DIVU: return (b == 0) ? 32'hffff_ffff : a / b;
    OP_REMU: return (b == 0) ? a : a % b;
    OP_DIV:  return (b == 0) ? 32'hffff_ffff : (ovf ? a : sq);
    default: return (b == 0) ? a : sr;
  endcase
endfunction

function automatic logic [31:0] ref_result(input logic [4:0] code, input logic [31:0] a, b);
  case (op_fu(code))
    FU_MUL:  return ref_mul(code, a, b);
    FU_DIV:  return ref_div(code, a, b);
    default: return ref_simple(code, a, b);
  endcase
endfunction

// Edges from acceptance to the edge that can consume the result
function automatic int latency_of(input logic [4:0] code);
  case (op_fu(code))
    FU_MUL:  return `MUL_STEPS + 2;
    FU_DIV:  return `DIV_STEPS + 2;
    default: return 1;
  endcase
endfunction

`endif

/* dv/mcalu_tb.sv */
// Testbench for the execution unit: stimulus, expected-result queue and checks
`timescale 1ns/1ps
`include "mcalu_defs.svh"

module mcalu_tb
  import mcalu_op_pkg::*, mcalu_fu_pkg::*;
();

  `include "mcalu_model.svh"

  localparam int N_CORNER = 16;
  localparam int N_PER_OP = N_CORNER + 8;
  localparam int N_STALL  = 24;
  localparam int N_FLUSH  = 8;
  // Base, multiply and divide runs, the stall run, three operations per flush round
  localparam int N_OPS    = 21 * N_PER_OP + N_STALL + 3 * N_FLUSH;
  localparam int TIMEOUT  = N_OPS * 40 + 500;

  localparam logic [`OP_W-1:0] BASE_OPS [13] = '{OP_ADD, OP_SUB, OP_SLL, OP_SLT, OP_SLTU,
    OP_XOR, OP_SEQ, OP_SRL, OP_SRA, OP_OR, OP_AND, OP_PFIND, OP_PCLR};
  localparam logic [`OP_W-1:0] MUL_OPS [4] = '{OP_MUL, OP_MULH, OP_MULHSU, OP_MULHU};
  localparam logic [`OP_W-1:0] DIV_OPS [4] = '{OP_DIV, OP_DIVU, OP_REM, OP_REMU};
  localparam logic [`OP_W-1:0] MIX_OPS [8] = '{OP_ADD, OP_MUL, OP_SRA, OP_DIVU,
    OP_PFIND, OP_MULHU, OP_SLT, OP_REM};

  typedef struct packed {
    logic [`XLEN-1:0]    result;
    logic [`ROBID_W-1:0] robid;
    logic [`RD_W-1:0]    rd;
  } exp_t;

  logic                clk = 1'b0;
  logic                arst_n;
  logic                issue;
  logic [`OP_W-1:0]    op;
  logic [`ROBID_W-1:0] robid;
  logic [`RD_W-1:0]    rd;
  logic [`XLEN-1:0]    op1;
  logic [`XLEN-1:0]    op2;
  logic                stall;
  logic                wb_valid;
  logic [`ROBID_W-1:0] wb_robid;
  logic [`RD_W-1:0]    wb_rd;
  logic [`XLEN-1:0]    wb_result;
  logic                wb_stall = 1'b0;
  logic                flush;

  exp_t        exp_q[$];
  exp_t        front;
  logic        front_ok = 1'b0;
  int          age = 0;
  int          exp_lat = 0;
  logic        wb_seen = 1'b0;
  logic        flushed = 1'b0;
  int          cycles = 0;
  logic [31:0] lfsr;
  logic [31:0] stall_lfsr = 32'd56;
  logic        stall_mode;
  logic        stall_on = 1'b0;
  int          stall_len = 0;
  string       test_name;

  mcalu uut (
    .clk       (clk),
    .arst_n    (arst_n),
    .issue     (issue),
    .op        (op),
    .robid     (robid),
    .rd        (rd),
    .op1       (op1),
    .op2       (op2),
    .stall     (stall),
    .wb_valid  (wb_valid),
    .wb_robid  (wb_robid),
    .wb_rd     (wb_rd),
    .wb_result (wb_result),
    .wb_stall  (wb_stall),
    .flush     (flush)
  );

  always #5 clk = ~clk;

  task automatic report_error(input string msg);
    $display("%s", msg);
    $display("** FAIL **");
    $fatal(1, "Stopped at the first error");
  endtask

  task automatic report_mismatch(input string field, input logic [31:0] exp_v, act_v);
    report_error($sformatf("CHECK FAILED %s %s expected %h actual %h",
                           test_name, field, exp_v, act_v));
  endtask

  // Expected entries follow accepted issues and consumed results
  always @(posedge clk) begin
    if (arst_n) begin
      if (wb_valid && !wb_stall && exp_q.size() > 0) begin
        void'(exp_q.pop_front());
      end
      if (flush) begin
        exp_q.delete();
        flushed <= 1'b1;
      end
      if (issue && !stall && !flush) begin
        exp_q.push_back({ref_result(op, op1, op2), robid, rd});
        age     <= 1;
        exp_lat <= latency_of(op);
        wb_seen <= 1'b0;
        flushed <= 1'b0;
      end else begin
        age <= age + 1;
        if (wb_valid) begin
          wb_seen <= 1'b1;
        end
      end
    end
    front_ok <= exp_q.size() > 0;
    if (exp_q.size() > 0) begin
      front <= exp_q[0];
    end
  end

  assert property (@(posedge clk) disable iff (!arst_n) wb_valid && !wb_stall |-> front_ok)
    else report_error("A result was written back with no operation outstanding");
  assert property (@(posedge clk) disable iff (!arst_n)
    wb_valid && !wb_stall && front_ok |-> wb_result == front.result)
    else report_mismatch("result", $sampled(front.result), $sampled(wb_result));
  assert property (@(posedge clk) disable iff (!arst_n)
    wb_valid && !wb_stall && front_ok |-> wb_robid == front.robid)
    else report_mismatch("robid", 32'($sampled(front.robid)), 32'($sampled(wb_robid)));
  assert property (@(posedge clk) disable iff (!arst_n)
    wb_valid && !wb_stall && front_ok |-> wb_rd == front.rd)
    else report_mismatch("rd", 32'($sampled(front.rd)), 32'($sampled(wb_rd)));
  assert property (@(posedge clk) disable iff (!arst_n) wb_valid && !wb_seen |-> age == exp_lat)
    else report_mismatch("latency", $sampled(exp_lat), $sampled(age));
  assert property (@(posedge clk) disable iff (!arst_n) wb_valid && !wb_stall |-> !stall)
    else report_error("stall was high on an edge that consumes a result");
  assert property (@(posedge clk) disable iff (!arst_n) wb_valid && wb_stall |-> stall)
    else report_error("stall dropped while writeback held a result");
  assert property (@(posedge clk) disable iff (!arst_n)
    $past(wb_valid && wb_stall) |-> wb_valid && $stable(wb_result) && $stable(wb_robid)
      && $stable(wb_rd))
    else report_error("Writeback ports moved while writeback was stalled");
  assert property (@(posedge clk) disable iff (!arst_n) flushed |-> !wb_valid)
    else report_error("A flushed operation was written back");

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT) begin
      report_error($sformatf("Timeout after %0d cycles, the tests did not finish", cycles));
    end
  end

  // Writeback stall held for random lengths
  always @(posedge clk) begin
    stall_on = stall_mode;
    #1;
    if (!stall_on) begin
      wb_stall = 1'b0;
    end else if (stall_len == 0) begin
      wb_stall = !wb_stall;
      stall_len = int'(draw(stall_lfsr, 3));
    end else begin
      stall_len = stall_len - 1;
    end
  end

  // Holds the operation until an edge with stall low takes it
  task automatic send(input logic [`OP_W-1:0] code, input logic [31:0] a, b);
    logic busy;
    issue = 1'b1;
    op    = code;
    robid = robid + 1'b1;
    rd    = `RD_W'(draw(lfsr, `RD_W));
    op1   = a;
    op2   = b;
    busy  = 1'b1;
    while (busy) begin
      @(negedge clk);
      busy = stall;
      @(posedge clk);
      #1;
    end
    issue = 1'b0;
  endtask

  task automatic send_random(input logic [`OP_W-1:0] code);
    logic [31:0] a;
    logic [31:0] b;
    a = draw(lfsr, 32);
    b = draw(lfsr, 32);
    send(code, a, b);
  endtask

  // All corner pairs, then random operands
  task automatic run_op(input logic [`OP_W-1:0] code);
    for (int i = 0; i < N_PER_OP; i++) begin
      if (i < N_CORNER) begin
        send(code, corner(i / 4), corner(i % 4));
      end else begin
        send_random(code);
      end
    end
  endtask

  task automatic wait_idle();
    do begin
      @(negedge clk);
    end while (stall || wb_valid || exp_q.size() != 0);
    @(posedge clk);
    #1;
  endtask

  initial begin
    int k;
    arst_n     = 1'b0;
    issue      = 1'b0;
    op         = OP_ADD;
    robid      = '0;
    rd         = '0;
    op1        = '0;
    op2        = '0;
    flush      = 1'b0;
    stall_mode = 1'b0;
    lfsr       = 32'd56;
    test_name  = "reset";
    repeat (5) @(posedge clk);
    #1;
    arst_n = 1'b1;

    test_name = "base_ops";
    foreach (BASE_OPS[i]) run_op(BASE_OPS[i]);
    wait_idle();

    test_name = "multiply";
    foreach (MUL_OPS[i]) run_op(MUL_OPS[i]);
    wait_idle();

    test_name = "divide";
    foreach (DIV_OPS[i]) run_op(DIV_OPS[i]);
    wait_idle();

    test_name  = "wb_stall";
    stall_mode = 1'b1;
    for (int i = 0; i < N_STALL; i++) begin
      send_random(MIX_OPS[i % 8]);
    end
    stall_mode = 1'b0;
    wait_idle();

    // Flush lands well before the unit can finish
    test_name = "flush";
    for (int i = 0; i < N_FLUSH; i++) begin
      send_random((i % 2 == 1) ? OP_DIV : OP_MULH);
      k = 2 + int'(draw(lfsr, 3));
      repeat (k) @(posedge clk);
      #1;
      flush = 1'b1;
      @(posedge clk);
      #1;
      flush = 1'b0;
      repeat (40) @(posedge clk);
      #1;
      send_random(OP_XOR);
      send_random(OP_MUL);
      wait_idle();
    end

    if (exp_q.size() != 0) begin
      report_error("Some expected results were never written back");
    end else begin
      $display("** PASS **");
      $finish;
    end
  end

endmodule

/* compile.f */
+incdir+rtl
+incdir+dv
rtl/mcalu_op_pkg.sv
rtl/mcalu_fu_pkg.sv
rtl/simple_alu.sv
rtl/booth_mul.sv
rtl/restoring_div.sv
rtl/mcalu.sv
dv/mcalu_tb.sv

/* run.sh */
#!/bin/sh
# Builds the execution unit testbench with Verilator and runs it
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
  -f compile.f \
  --top-module mcalu_tb \
  -Mdir obj_dir \
  -o mcalu_tb

./obj_dir/mcalu_tb 2>&1 | tee sim.log

if grep -qx '\*\* PASS \*\*' sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed, see sim.log"
  exit 1
fi
